/* Bender.yml */
package:
  name: wb_io_subsys

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - rtl/wb_io_pkg.sv
      - rtl/wb_addr_decoder.sv
      - rtl/wb_scratch_ram.sv
      - rtl/wb_seg_ctrl.sv
      - rtl/wb_io_subsys.sv

  - target: test
    files:
      - bench/wb_io_subsys_tb.sv

/* bench/wb_io_subsys_tb.sv */
module wb_io_subsys_tb
  import wb_io_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAM   = 200;
  localparam int N_RAW   = 40;
  localparam int N_HEX   = 20;
  localparam int N_NUL   = 16;
  localparam int N_TRANS = 2 + 2 * N_RAM + 3 * N_RAW + 2 * N_HEX + 4 * N_NUL + 4;
  localparam int TIMEOUT = N_TRANS * 200 + 8;

  // Active high lit segments per hex value in gfedcba order
  localparam logic [6:0] SEG_ON [16] = '{
    7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
  };

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              cyc_i;
  logic              stb_i;
  logic              we_i;
  logic [ADDR_W-1:0] adr_i;
  logic [DATA_W-1:0] dat_i;
  logic [SEL_W-1:0]  sel_i;
  logic              ack_o;
  logic [DATA_W-1:0] dat_o;
  logic [7:0]        hex_out [SEG_DIGITS];

  // Reference model
  logic [DATA_W-1:0] ram_m [RAM_WORDS];
  logic [7:0]        digit_m [SEG_DIGITS];
  logic [7:0]        glyph_m [16];
  seg_word_u         hex_m;
  int                wr_list [$];   // word indexes written so far

  integer seed;
  int     errors = 0;
  int     cycles = 0;

  wb_io_subsys DUT (
    .clk_i, .rst_n_i,
    .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i, .ack_o, .dat_o,
    .hex0_o(hex_out[0]), .hex1_o(hex_out[1]), .hex2_o(hex_out[2]),
    .hex3_o(hex_out[3]), .hex4_o(hex_out[4]), .hex5_o(hex_out[5])
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("Run timed out after %0d cycles before all transactions finished", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  // One handshake that starts and ends 5 ns after a rising edge
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel, input int hold,
                            output logic [31:0] rdat);
    int waits;
    waits = 0;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    dat_i = wdat;
    sel_i = sel;
    do begin
      @(posedge clk_i);
      #5;
      waits++;
    end while (ack_o !== 1'b1);
    check(waits, 1, "ack latency in cycles");
    rdat = dat_o;
    repeat (hold) begin // stb kept high after ack
      @(posedge clk_i);
      #5;
      check(ack_o, 1'b0, "extra ack while stb held");
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(posedge clk_i);
    #5;
    check(ack_o, 1'b0, "ack repeated after request ended");
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat,
                           input logic [3:0] sel);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdat, sel, 0, unused);
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
    bus_access(1'b0, adr, '0, '1, 0, rdat);
  endtask

  function automatic logic [31:0] ram_adr(input int idx, input logic [31:0] junk);
    return {SLOT_RAM, junk[15:0], RAM_AW'(idx), 2'b00};
  endfunction

  function automatic logic [31:0] seg_adr(input logic [1:0] ofs, input logic [31:0] junk);
    return {SLOT_SEG, junk[23:0], ofs, 2'b00};
  endfunction

  task automatic ram_model_write(input int idx, input logic [31:0] wdat, input logic [3:0] sel);
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) ram_m[idx][b*8 +: 8] = wdat[b*8 +: 8];
    end
  endtask

  task automatic seg_model_write(input logic [1:0] ofs, input logic [31:0] wdat,
                                 input logic [3:0] sel);
    seg_word_u w;
    w = wdat;
    case (ofs)
      SEG_REG_RAW_LO: begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) digit_m[b] = w.raw[b];
        end
      end
      SEG_REG_RAW_HI: begin
        for (int b = 0; b < 2; b++) begin
          if (sel[b]) digit_m[4+b] = w.raw[b];
        end
      end
      SEG_REG_HEX: begin
        hex_m = w;
        for (int d = 0; d < SEG_DIGITS; d++) begin
          digit_m[d] = glyph_m[w.hex[d]];
        end
      end
      default: ;
    endcase
  endtask

  function automatic logic [31:0] raw_lo_exp();
    seg_word_u w;
    w = '0;
    for (int d = 0; d < 4; d++) begin
      w.raw[d] = digit_m[d];
    end
    return w;
  endfunction

  function automatic logic [31:0] raw_hi_exp();
    seg_word_u w;
    w = '0;
    w.raw[0] = digit_m[4];
    w.raw[1] = digit_m[5];
    return w;
  endfunction

  task automatic check_digits(input string msg);
    for (int d = 0; d < SEG_DIGITS; d++) begin
      check(hex_out[d], digit_m[d], msg);
    end
  endtask

  initial begin
    int          idx;
    logic [31:0] wdat;
    logic [31:0] rdat;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [1:0]  ofs;
    logic [3:0]  slot;

    seed    = 27;
    rst_n_i = 1'b0;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    adr_i   = '0;
    dat_i   = '0;
    sel_i   = '0;
    for (int n = 0; n < 16; n++) begin
      glyph_m[n] = {1'b1, ~SEG_ON[n]}; // dp dark
    end
    for (int d = 0; d < SEG_DIGITS; d++) begin
      digit_m[d] = SEG_BLANK;
    end
    hex_m = '0;
    repeat (8) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;

    check(ack_o, 1'b0, "ack after reset");
    check_digits("digit after reset");
    bus_read(seg_adr(SEG_REG_RAW_LO, $random(seed)), rdat);
    check(rdat, 32'hFFFF_FFFF, "RAW_LO after reset");
    bus_read(seg_adr(SEG_REG_HEX, $random(seed)), rdat);
    check(rdat, 32'h0, "HEX after reset");

    for (int i = 0; i < N_RAM; i++) begin
      idx  = {$random(seed)} % RAM_WORDS;
      wdat = $random(seed);
      sel  = $random(seed);
      bus_write(ram_adr(idx, $random(seed)), wdat, sel);
      ram_model_write(idx, wdat, sel);
      wr_list.push_back(idx);
      idx = wr_list[{$random(seed)} % wr_list.size()];
      bus_read(ram_adr(idx, $random(seed)), rdat);
      check(rdat, ram_m[idx], "RAM read");
    end

    for (int i = 0; i < N_RAW; i++) begin
      ofs  = ($random(seed) & 1) ? SEG_REG_RAW_HI : SEG_REG_RAW_LO;
      wdat = $random(seed);
      sel  = $random(seed);
      bus_write(seg_adr(ofs, $random(seed)), wdat, sel);
      seg_model_write(ofs, wdat, sel);
      check_digits("digit after raw write");
      bus_read(seg_adr(SEG_REG_RAW_LO, $random(seed)), rdat);
      check(rdat, raw_lo_exp(), "RAW_LO readback");
      bus_read(seg_adr(SEG_REG_RAW_HI, $random(seed)), rdat);
      check(rdat, raw_hi_exp(), "RAW_HI readback");
    end

    for (int i = 0; i < N_HEX; i++) begin
      wdat = $random(seed);
      sel  = $random(seed); // HEX ignores sel
      bus_write(seg_adr(SEG_REG_HEX, $random(seed)), wdat, sel);
      seg_model_write(SEG_REG_HEX, wdat, sel);
      check_digits("digit after hex write");
      bus_read(seg_adr(SEG_REG_HEX, $random(seed)), rdat);
      check(rdat, hex_m, "HEX readback");
    end

    // Unmapped slots on even passes and segment offset 3 on odd ones
    for (int i = 0; i < N_NUL; i++) begin
      idx = wr_list[{$random(seed)} % wr_list.size()]; // RAM word a stray access would hit
      if (i % 2 == 1) begin // offset 3 needs word index bits 1:0 set
        foreach (wr_list[k]) begin
          if (idx % 4 != 3) idx = wr_list[k];
        end
      end
      if (i % 2 == 0) begin
        do begin
          slot = $random(seed);
        end while (slot == SLOT_RAM || slot == SLOT_SEG);
      end else begin
        slot = SLOT_SEG;
      end
      adr = {slot, 16'($random(seed)), RAM_AW'(idx), 2'b00};
      bus_write(adr, $random(seed), $random(seed));
      bus_read(adr, rdat);
      check(rdat, 32'h0, "unmapped read");
      check_digits("digit after unmapped access");
      bus_read(ram_adr(idx, $random(seed)), rdat);
      check(rdat, ram_m[idx], "RAM after unmapped access");
      bus_read(seg_adr(SEG_REG_HEX, $random(seed)), rdat);
      check(rdat, hex_m, "HEX after unmapped access");
    end

    idx  = wr_list[0];
    wdat = $random(seed);
    sel  = $random(seed);
    bus_access(1'b1, ram_adr(idx, $random(seed)), wdat, sel, 4, rdat);
    ram_model_write(idx, wdat, sel);
    bus_read(ram_adr(idx, $random(seed)), rdat);
    check(rdat, ram_m[idx], "RAM after held write");
    wdat = $random(seed);
    bus_access(1'b1, seg_adr(SEG_REG_HEX, $random(seed)), wdat, 4'hF, 4, rdat);
    seg_model_write(SEG_REG_HEX, wdat, 4'hF);
    check_digits("digit after held hex write");
    bus_access(1'b0, {4'h7, 28'($random(seed))}, '0, 4'hF, 4, rdat);
    check(rdat, 32'h0, "held unmapped read");

    $display("Run complete after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rtl/wb_addr_decoder.sv */
module wb_addr_decoder
  import wb_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Master side
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  // RAM slot
  output logic              ram_cyc_o,
  output logic              ram_stb_o,
  output logic              ram_we_o,
  output logic [RAM_AW-1:0] ram_adr_o,
  output logic [DATA_W-1:0] ram_dat_o,
  output logic [SEL_W-1:0]  ram_sel_o,
  input  logic              ram_ack_i,
  input  logic [DATA_W-1:0] ram_dat_i,
  // Segment slot
  output logic              seg_cyc_o,
  output logic              seg_stb_o,
  output logic              seg_we_o,
  output logic [SEG_AW-1:0] seg_adr_o,
  output logic [DATA_W-1:0] seg_dat_o,
  output logic [SEL_W-1:0]  seg_sel_o,
  input  logic              seg_ack_i,
  input  logic [DATA_W-1:0] seg_dat_i
);

  logic [SLOT_W-1:0] slot;
  logic              hit_ram;
  logic              hit_seg;
  logic              hit_none;
  logic              nul_ack_q;
  logic              nul_held_q;

  assign slot     = adr_i[SLOT_MSB:SLOT_LSB];
  assign hit_ram  = (slot == SLOT_RAM);
  assign hit_seg  = (slot == SLOT_SEG);
  assign hit_none = ~hit_ram & ~hit_seg;

  assign ram_cyc_o = cyc_i & hit_ram;
  assign ram_stb_o = stb_i & hit_ram;
  assign ram_we_o  = we_i;
  assign ram_adr_o = adr_i[RAM_AW+1:2]; // slot bits stripped
  assign ram_dat_o = dat_i;
  assign ram_sel_o = sel_i;

  assign seg_cyc_o = cyc_i & hit_seg;
  assign seg_stb_o = stb_i & hit_seg;
  assign seg_we_o  = we_i;
  assign seg_adr_o = adr_i[SEG_AW+1:2];
  assign seg_dat_o = dat_i;
  assign seg_sel_o = sel_i;

  // Unmapped slots answer on their own so a stray access cannot hang
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nul_ack_q  <= 1'b0;
      nul_held_q <= 1'b0;
    end else begin
      nul_ack_q  <= cyc_i & stb_i & hit_none & ~nul_ack_q & ~nul_held_q;
      nul_held_q <= cyc_i & stb_i & hit_none & (nul_held_q | nul_ack_q);
    end
  end

  assign ack_o = (hit_ram & ram_ack_i) | (hit_seg & seg_ack_i) | nul_ack_q;
  assign dat_o = hit_ram ? ram_dat_i :
                 hit_seg ? seg_dat_i : '0; // unmapped reads zero

endmodule

/* rtl/wb_io_pkg.sv */
package wb_io_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Slot select on the top address nibble
  localparam int SLOT_MSB = 31;
  localparam int SLOT_LSB = 28;
  localparam int SLOT_W   = SLOT_MSB - SLOT_LSB + 1;
  localparam logic [SLOT_W-1:0] SLOT_RAM = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_SEG = 4'd3;

  localparam int RAM_AW    = 10; // Word address from bits 11:2
  localparam int RAM_WORDS = 1 << RAM_AW;

  localparam int SEG_DIGITS = 6;
  localparam int SEG_AW     = 2;
  localparam logic [SEG_AW-1:0] SEG_REG_RAW_LO = 2'd0;
  localparam logic [SEG_AW-1:0] SEG_REG_RAW_HI = 2'd1;
  localparam logic [SEG_AW-1:0] SEG_REG_HEX    = 2'd2;
  localparam logic [7:0]        SEG_BLANK      = 8'hFF; // Active low with dp in bit 7

  // One register word seen as segment bytes or as hex nibbles
  typedef union packed {
    logic [3:0][7:0] raw;
    logic [7:0][3:0] hex;
  } seg_word_u;

  // Active low glyph for one nibble with dp dark
  function automatic logic [7:0] seg_glyph(input logic [3:0] nib);
    logic [6:0] on; // Active high in gfedcba order
    case (nib)
      4'h0:    on = 7'h3F;
      4'h1:    on = 7'h06;
      4'h2:    on = 7'h5B;
      4'h3:    on = 7'h4F;
      4'h4:    on = 7'h66;
      4'h5:    on = 7'h6D;
      4'h6:    on = 7'h7D;
      4'h7:    on = 7'h07;
      4'h8:    on = 7'h7F;
      4'h9:    on = 7'h6F;
      4'hA:    on = 7'h77;
      4'hB:    on = 7'h7C;
      4'hC:    on = 7'h39;
      4'hD:    on = 7'h5E;
      4'hE:    on = 7'h79;
      default: on = 7'h71;
    endcase
    return {1'b1, ~on};
  endfunction

endpackage

/* rtl/wb_io_subsys.sv */
module wb_io_subsys
  import wb_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  output logic [7:0]        hex0_o,
  output logic [7:0]        hex1_o,
  output logic [7:0]        hex2_o,
  output logic [7:0]        hex3_o,
  output logic [7:0]        hex4_o,
  output logic [7:0]        hex5_o
);

  logic              ram_cyc, ram_stb, ram_we, ram_ack;
  logic [RAM_AW-1:0] ram_adr;
  logic [DATA_W-1:0] ram_wdat, ram_rdat;
  logic [SEL_W-1:0]  ram_sel;
  logic              seg_cyc, seg_stb, seg_we, seg_ack;
  logic [SEG_AW-1:0] seg_adr;
  logic [DATA_W-1:0] seg_wdat, seg_rdat;
  logic [SEL_W-1:0]  seg_sel;

  wb_addr_decoder u_dec (
    .clk_i, .rst_n_i,
    .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i, .ack_o, .dat_o,
    .ram_cyc_o(ram_cyc), .ram_stb_o(ram_stb), .ram_we_o(ram_we),
    .ram_adr_o(ram_adr), .ram_dat_o(ram_wdat), .ram_sel_o(ram_sel),
    .ram_ack_i(ram_ack), .ram_dat_i(ram_rdat),
    .seg_cyc_o(seg_cyc), .seg_stb_o(seg_stb), .seg_we_o(seg_we),
    .seg_adr_o(seg_adr), .seg_dat_o(seg_wdat), .seg_sel_o(seg_sel),
    .seg_ack_i(seg_ack), .seg_dat_i(seg_rdat)
  );

  wb_scratch_ram u_ram (
    .clk_i, .rst_n_i,
    .cyc_i(ram_cyc), .stb_i(ram_stb), .we_i(ram_we),
    .adr_i(ram_adr), .dat_i(ram_wdat), .sel_i(ram_sel),
    .ack_o(ram_ack), .dat_o(ram_rdat)
  );

  wb_seg_ctrl u_seg (
    .clk_i, .rst_n_i,
    .cyc_i(seg_cyc), .stb_i(seg_stb), .we_i(seg_we),
    .adr_i(seg_adr), .dat_i(seg_wdat), .sel_i(seg_sel),
    .ack_o(seg_ack), .dat_o(seg_rdat),
    .hex0_o, .hex1_o, .hex2_o, .hex3_o, .hex4_o, .hex5_o
  );

endmodule

/* rtl/wb_scratch_ram.sv */
module wb_scratch_ram
  import wb_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [RAM_AW-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic              req;
  logic              acc;
  logic              held_q;

  assign req = cyc_i & stb_i;
  assign acc = req & ~ack_o & ~held_q; // one accept per request

  // held_q stays up while the master keeps stb after its ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      held_q <= 1'b0;
    end else begin
      ack_o  <= acc;
      held_q <= req & (held_q | ack_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc && we_i) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b]) begin
          mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
        end
      end
    end
    if (acc) begin
      dat_o <= mem[adr_i]; // old word on a write
    end
  end

endmodule

/* rtl/wb_seg_ctrl.sv */
module wb_seg_ctrl
  import wb_io_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [SEG_AW-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  output logic [7:0]        hex0_o,
  output logic [7:0]        hex1_o,
  output logic [7:0]        hex2_o,
  output logic [7:0]        hex3_o,
  output logic [7:0]        hex4_o,
  output logic [7:0]        hex5_o
);

  logic [7:0] digit_q [SEG_DIGITS];
  seg_word_u  hex_q;    // last word written to HEX
  seg_word_u  wr_word;
  seg_word_u  rd_word;
  logic       req;
  logic       acc;
  logic       held_q;

  assign req     = cyc_i & stb_i;
  assign acc     = req & ~ack_o & ~held_q;
  assign wr_word = dat_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      held_q <= 1'b0;
      hex_q  <= '0;
      for (int d = 0; d < SEG_DIGITS; d++) begin
        digit_q[d] <= SEG_BLANK;
      end
    end else begin
      ack_o  <= acc;
      held_q <= req & (held_q | ack_o);
      if (acc && we_i) begin
        case (adr_i)
          SEG_REG_RAW_LO: begin
            for (int b = 0; b < 4; b++) begin
              if (sel_i[b]) digit_q[b] <= wr_word.raw[b];
            end
          end
          SEG_REG_RAW_HI: begin
            for (int b = 0; b < SEG_DIGITS - 4; b++) begin
              if (sel_i[b]) digit_q[4+b] <= wr_word.raw[b];
            end
          end
          SEG_REG_HEX: begin // Whole word with sel ignored
            hex_q <= wr_word;
            for (int d = 0; d < SEG_DIGITS; d++) begin
              digit_q[d] <= seg_glyph(wr_word.hex[d]);
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (adr_i)
      SEG_REG_RAW_LO: for (int d = 0; d < 4; d++) rd_word.raw[d] = digit_q[d];
      SEG_REG_RAW_HI: for (int d = 0; d < SEG_DIGITS - 4; d++) rd_word.raw[d] = digit_q[4+d];
      SEG_REG_HEX:    rd_word = hex_q;
      default: ;      // offset 3 reads zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) dat_o <= rd_word;
  end

  assign hex0_o = digit_q[0];
  assign hex1_o = digit_q[1];
  assign hex2_o = digit_q[2];
  assign hex3_o = digit_q[3];
  assign hex4_o = digit_q[4];
  assign hex5_o = digit_q[5];

endmodule

/* wb_io_subsys.f */
rtl/wb_io_pkg.sv
rtl/wb_addr_decoder.sv
rtl/wb_scratch_ram.sv
rtl/wb_seg_ctrl.sv
rtl/wb_io_subsys.sv
bench/wb_io_subsys_tb.sv
